// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_serial_bridge
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hdl/bridge_pkg.sv
hdl/stream_if.sv
hdl/uart_frame_rx.sv
hdl/frame_splitter.sv
hdl/word_fifo.sv
hdl/uart_word_tx.sv
hdl/serial_bridge_top.sv
tests/serial_bridge_sva.sv
tests/tb_serial_bridge.sv

// File: hdl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  typedef logic [63:0] frame_t; // eight data bytes, first byte received in 63..56
  typedef logic [23:0] word_t;  // outgoing word, three bytes
  typedef logic [7:0]  byte_t;  // one serial byte

  localparam int FRAME_BYTES = 8; // data bytes per frame, checksum not counted
  localparam int WORD_BYTES  = 3; // data bytes per word

  // xor of the low n bytes of data
  // shorter payloads are zero extended into a frame_t by the caller
  function automatic byte_t xor_sum(input frame_t data, input int unsigned n);
    byte_t acc;
    acc = '0;
    for (int i = 0; i < FRAME_BYTES; i++) begin
      if (i < n) acc ^= data[8*i +: 8]; // bytes above n ignored
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

// File: hdl/frame_splitter.sv
`default_nettype none

module frame_splitter import bridge_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  stream_if.sink   frame_i,
  stream_if.source word_o
);

  logic       busy;    // holding a frame
  logic [1:0] idx;     // word being offered, 0..2
  frame_t     frame_q; // accepted frame

  assign frame_i.ready = !busy; // one frame at a time
  assign word_o.valid  = busy;
  assign word_o.last   = (idx == 2'd2);

  // slice for the current word
  always_comb begin
    case (idx)
      2'd0:    word_o.data = frame_q[63:40];
      2'd1:    word_o.data = frame_q[39:16];
      default: word_o.data = {8'h00, frame_q[15:0]}; // pad high byte
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (!busy) begin
      if (frame_i.valid) begin
        busy <= 1'b1;
        idx  <= '0; // word 0 offered next cycle
      end
    end else if (word_o.ready) begin
      // word taken
      if (idx == 2'd2) begin
        busy <= 1'b0;
        idx  <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_i.valid && frame_i.ready) frame_q <= frame_i.data; // payload only
  end

endmodule

`default_nettype wire

// File: hdl/serial_bridge_top.sv
`default_nettype none

module serial_bridge_top import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = 16,
  parameter int FIFO_DEPTH   = 8 // power of two
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic rx_i,
  output logic tx_o,
  output logic frame_err_o, // sticky until reset
  output logic busy_o
);

  stream_if #(.payload_t(frame_t)) frame_s (); // rx to splitter
  stream_if #(.payload_t(word_t))  word_s ();  // splitter to fifo
  stream_if #(.payload_t(word_t))  out_s ();   // fifo to tx

  logic fifo_empty;
  logic tx_active;

  uart_frame_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_i        (rx_i),
    .frame_err_o (frame_err_o),
    .frame_o     (frame_s)
  );

  frame_splitter u_split (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .frame_i (frame_s),
    .word_o  (word_s)
  );

  word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wr_i    (word_s),
    .rd_o    (out_s),
    .empty_o (fifo_empty)
  );

  uart_word_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .word_i   (out_s),
    .tx_o     (tx_o),
    .active_o (tx_active)
  );

  // any stage holding data, or the line still sending
  assign busy_o = frame_s.valid | word_s.valid | ~fifo_empty | tx_active;

endmodule

`default_nettype wire

// File: hdl/stream_if.sv
`default_nettype none

// valid/ready stream, one payload per transfer
interface stream_if #(
  parameter type payload_t = logic [7:0]
);

  logic     valid; // source has data
  logic     ready; // sink can take it
  payload_t data;
  logic     last;  // final word of a frame

  modport source (output valid, output data, output last, input ready);
  modport sink   (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// File: hdl/uart_frame_rx.sv
`default_nettype none

module uart_frame_rx import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    rx_i,
  output logic    frame_err_o,
  stream_if.source frame_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1); // mid of start bit
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta, rx_sync; // two flop synchronizer
  logic [CNT_W-1:0] clk_cnt;           // cycles within a bit
  logic [2:0]       bit_cnt;           // data bit index
  logic [3:0]       byte_cnt;          // 0..7 data, 8 checksum
  byte_t            rx_byte;           // lsb first shift in
  frame_t           frame_sr;          // data bytes collected so far
  logic             hold_busy;

  // previous frame still waiting for the splitter
  assign hold_busy = frame_o.valid && !frame_o.ready;

  assign frame_o.last = 1'b1; // each frame is a complete unit

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta <= 1'b1; // idle line is high
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state         <= S_IDLE;
      clk_cnt       <= '0;
      bit_cnt       <= '0;
      byte_cnt      <= '0;
      frame_err_o   <= 1'b0;
      frame_o.valid <= 1'b0;
    end else begin
      if (frame_o.valid && frame_o.ready) frame_o.valid <= 1'b0; // handed over

      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) state <= S_START; // falling edge, start bit
        end
        S_START: begin
          if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? S_IDLE : S_DATA; // glitch returns to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            rx_byte <= {rx_sync, rx_byte[7:1]}; // lsb arrives first
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= S_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_STOP: begin
          if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            state   <= S_IDLE;
            if (!rx_sync) begin
              // framing error, restart frame
              frame_err_o <= 1'b1;
              byte_cnt    <= '0;
            end else if (byte_cnt != 4'(FRAME_BYTES)) begin
              frame_sr <= {frame_sr[55:0], rx_byte}; // first byte ends up on top
              byte_cnt <= byte_cnt + 1'b1;
            end else begin
              byte_cnt <= '0;
              // checksum byte just arrived
              if (xor_sum(frame_sr, FRAME_BYTES) != rx_byte || hold_busy) begin
                frame_err_o <= 1'b1; // bad sum or no room, drop
              end else begin
                frame_o.valid <= 1'b1;
                frame_o.data  <= frame_sr;
              end
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_word_tx.sv
`default_nettype none

module uart_word_tx import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic   clk,
  input  logic   rst_n_i,
  stream_if.sink word_i,
  output logic   tx_o,
  output logic   active_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] clk_cnt;  // cycles within a bit
  logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [1:0]       byte_cnt; // 0..2 data bytes, 3 checksum
  logic [9:0]       line_sr;  // framed byte, bit 0 on the line
  logic [23:0]      tx_buf;   // bytes still to go, next on top
  byte_t            sum;

  assign word_i.ready = !active_o; // take a word only when idle
  assign tx_o         = line_sr[0];
  assign sum          = xor_sum(frame_t'(word_i.data), WORD_BYTES);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      active_o <= 1'b0;
      line_sr  <= '1; // line idles high
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else if (!active_o) begin
      if (word_i.valid) begin
        active_o <= 1'b1;
        line_sr  <= {1'b1, word_i.data[23:16], 1'b0}; // msb byte first
        clk_cnt  <= '0;
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end
    end else if (clk_cnt != FULL_BIT) begin
      clk_cnt <= clk_cnt + 1'b1;
    end else begin
      clk_cnt <= '0;
      if (bit_cnt != 4'd9) begin
        line_sr <= {1'b1, line_sr[9:1]}; // next bit, ones shift in
        bit_cnt <= bit_cnt + 1'b1;
      end else if (byte_cnt == 2'd3) begin
        active_o <= 1'b0; // checksum stop bit done
        line_sr  <= '1;
      end else begin
        // next byte right after the stop bit
        line_sr  <= {1'b1, tx_buf[23:16], 1'b0};
        bit_cnt  <= '0;
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_i.valid && word_i.ready) begin
      tx_buf <= {word_i.data[15:0], sum}; // remaining bytes plus checksum
    end else if (active_o && clk_cnt == FULL_BIT && bit_cnt == 4'd9) begin
      tx_buf <= {tx_buf[15:0], 8'h00};
    end
  end

endmodule

`default_nettype wire

// File: hdl/word_fifo.sv
`default_nettype none

module word_fifo import bridge_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic     clk,
  input  logic     rst_n_i,
  stream_if.sink   wr_i,
  stream_if.source rd_o,
  output logic     empty_o
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  word_t           mem_data [FIFO_DEPTH];
  logic            mem_last [FIFO_DEPTH]; // last flag beside each word
  logic [ADDR_W:0] wr_ptr, rd_ptr;        // extra bit tells full from empty
  logic            mem_empty, full;
  logic            stage_free, wr_fire, bypass, wr_en, rd_en;

  assign mem_empty = (wr_ptr == rd_ptr);
  assign full      = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign wr_i.ready = !full;
  assign wr_fire    = wr_i.valid && !full;
  assign stage_free = !rd_o.valid || rd_o.ready; // output reg empty or leaving
  assign rd_en      = stage_free && !mem_empty;
  assign bypass     = stage_free && mem_empty && wr_fire; // straight to output reg
  assign wr_en      = wr_fire && !bypass;
  assign empty_o    = mem_empty && !rd_o.valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr[ADDR_W-1:0]] <= wr_i.data;
      mem_last[wr_ptr[ADDR_W-1:0]] <= wr_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      rd_o.valid <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (stage_free) rd_o.valid <= !mem_empty || wr_fire;
    end
  end

  // output register, oldest entry wins over bypass
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_o.data <= mem_data[rd_ptr[ADDR_W-1:0]];
      rd_o.last <= mem_last[rd_ptr[ADDR_W-1:0]];
    end else if (bypass) begin
      rd_o.data <= wr_i.data;
      rd_o.last <= wr_i.last;
    end
  end

endmodule

`default_nettype wire

// File: tests/frame_cases.txt
# column 1 holds the 64-bit frame in hex with its top byte sent first
# column 2 is 1 when one bit of the checksum byte gets flipped
0123456789abcdef 0
fedcba9876543210 0
deadbeefcafef00d 1
0000000000000000 0
ffffffffffffffff 0
a5a55a5a3c3cc3c3 0
8000000000000001 1
13579bdf2468ace0 0
00ff00ff00ff00ff 0
7e1f0c9b55aa0042 0

// File: tests/serial_bridge_sva.sv
`default_nettype none

// stream, fifo and line checks for one stage
module serial_bridge_sva #(
  parameter int W = 64 // payload width
) (
  input logic         clk,
  input logic         rst_n_i,
  input logic         valid_i,
  input logic         ready_i,
  input logic [W-1:0] data_i,
  input logic         last_i,
  input logic         push_i,   // fifo memory write
  input logic         full_i,
  input logic         line_i,   // serial output
  input logic         active_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0; // summed by the testbench

  stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(last_i))
    else begin
      fail_cnt++;
      $error("stream payload moved while stalled");
    end

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk) $rose(rst_n_i) |-> !valid_i)
    else begin
      fail_cnt++;
      $error("valid high right after reset");
    end

  no_overrun: assert property (@(posedge clk) disable iff (!rst_n_i) !(push_i && full_i))
    else begin
      fail_cnt++;
      $error("fifo written while full");
    end

  line_idle: assert property (@(posedge clk) disable iff (!rst_n_i) !active_i |-> line_i)
    else begin
      fail_cnt++;
      $error("serial line low while transmitter idle");
    end

endmodule

bind uart_frame_rx serial_bridge_sva #(.W(64)) rx_chk (
  .clk(clk), .rst_n_i(rst_n_i), .valid_i(frame_o.valid), .ready_i(frame_o.ready),
  .data_i(frame_o.data), .last_i(frame_o.last), .push_i(1'b0), .full_i(1'b0),
  .line_i(1'b1), .active_i(1'b1)
);

bind frame_splitter serial_bridge_sva #(.W(24)) split_chk (
  .clk(clk), .rst_n_i(rst_n_i), .valid_i(word_o.valid), .ready_i(word_o.ready),
  .data_i(word_o.data), .last_i(word_o.last), .push_i(1'b0), .full_i(1'b0),
  .line_i(1'b1), .active_i(1'b1)
);

// full taken from pointer occupancy, not from the fifo's own decode
bind word_fifo serial_bridge_sva #(.W(24)) fifo_chk (
  .clk(clk), .rst_n_i(rst_n_i), .valid_i(rd_o.valid), .ready_i(rd_o.ready),
  .data_i(rd_o.data), .last_i(rd_o.last), .push_i(wr_en),
  .full_i(wr_ptr - rd_ptr == (ADDR_W+1)'(FIFO_DEPTH)),
  .line_i(1'b1), .active_i(1'b1)
);

bind uart_word_tx serial_bridge_sva #(.W(24)) tx_chk (
  .clk(clk), .rst_n_i(rst_n_i), .valid_i(1'b0), .ready_i(1'b1),
  .data_i('0), .last_i(1'b0), .push_i(1'b0), .full_i(1'b0),
  .line_i(tx_o), .active_i(active_o)
);

`default_nettype wire

// File: tests/tb_serial_bridge.sv
`default_nettype none

module tb_serial_bridge import bridge_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_BIT = 8;
  localparam int FIFO_DEPTH   = 8;
  localparam int CLK_NS       = 8;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam int MAX_GAP      = 40; // idle bit times between frames

  logic   clk;
  logic   rst_n_i;
  logic   rx_i;
  logic   tx_o;
  logic   frame_err_o;
  logic   busy_o;

  frame_t case_frame [$]; // frames from the cases file
  logic   case_bad   [$]; // checksum to be spoiled
  word_t  exp_q      [$]; // words still due on tx_o
  int     n_exp_words;
  int     n_rx_words;
  int     n_checks;
  int     n_errors;
  int     sva_fails;
  logic   seen_bad;       // a corrupt frame went out already
  integer seed;

  serial_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .frame_err_o (frame_err_o),
    .busy_o      (busy_o)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic read_cases;
    int     fd;
    string  line;
    frame_t f;
    int     bad;
    fd = $fopen("tests/frame_cases.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open tests/frame_cases.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") continue; // column notes
      if ($sscanf(line, "%h %d", f, bad) == 2) begin
        case_frame.push_back(f);
        case_bad.push_back(bad != 0);
      end
    end
    $fclose(fd);
    if (case_frame.size() == 0) begin
      n_errors++;
      $display("no test cases found in tests/frame_cases.txt");
    end
  endtask

  // split rule, both passes send the same list
  task automatic queue_expected;
    frame_t f;
    for (int p = 0; p < 2; p++) begin
      foreach (case_frame[i]) begin
        if (!case_bad[i]) begin
          f = case_frame[i];
          exp_q.push_back(f[63:40]);
          exp_q.push_back(f[39:16]);
          exp_q.push_back({8'h00, f[15:0]}); // zero high byte
        end
      end
    end
    n_exp_words = exp_q.size();
  endtask

  task automatic send_bit(input logic b);
    @(posedge clk);
    #1 rx_i = b;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  task automatic send_byte(input byte_t b);
    send_bit(1'b0); // start
    for (int i = 0; i < 8; i++) send_bit(b[i]); // lsb first
    send_bit(1'b1); // stop
  endtask

  task automatic send_frame(input frame_t f, input logic bad);
    byte_t sum;
    sum = '0;
    for (int i = 7; i >= 0; i--) begin
      send_byte(f[8*i +: 8]); // top byte goes first
      sum ^= f[8*i +: 8];
    end
    if (bad) sum ^= 8'h04; // one spoiled bit
    send_byte(sum);
  endtask

  task automatic send_pass(input logic with_gaps);
    int gap;
    foreach (case_frame[i]) begin
      @(negedge clk);
      check_flag("frame_err_o", frame_err_o, seen_bad); // sticky from first bad frame
      send_frame(case_frame[i], case_bad[i]);
      seen_bad |= case_bad[i];
      gap = with_gaps ? $unsigned($random(seed)) % (MAX_GAP + 1) : 0;
      repeat (gap * CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  // one framed byte off tx_o, sampled mid bit on the falling clock
  task automatic recv_byte(output byte_t b, output logic stop);
    @(negedge tx_o);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop = tx_o;
  endtask

  task automatic monitor_tx;
    byte_t b [4];
    logic  stop;
    word_t exp_w;
    forever begin
      for (int k = 0; k < 4; k++) begin
        recv_byte(b[k], stop);
        check_flag("tx_o stop bit", stop, 1'b1);
      end
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("word %h came out on tx_o but none was expected", {b[0], b[1], b[2]});
      end else begin
        exp_w = exp_q.pop_front();
        check_word("tx_o word", {b[0], b[1], b[2]}, exp_w);
        check_byte("tx_o checksum", b[3], exp_w[23:16] ^ exp_w[15:8] ^ exp_w[7:0]);
      end
      n_rx_words++;
    end
  endtask

  // busy drops after the last stop bit and stays down while rx_i idles
  task automatic wait_idle(input int words_due);
    int   waited;
    logic busy_seen;
    logic low_seen;
    wait (n_rx_words >= words_due);
    waited = 0;
    while (busy_o && waited < 2 * CLKS_PER_BIT) begin
      @(negedge clk);
      waited++;
    end
    check_flag("busy_o", busy_o, 1'b0);
    busy_seen = 1'b0;
    low_seen  = 1'b0;
    repeat (16 * CLKS_PER_BIT) begin
      @(negedge clk);
      busy_seen |= busy_o;
      low_seen  |= !tx_o;
    end
    check_flag("busy_o while idle", busy_seen, 1'b0);
    check_flag("tx_o low while idle", low_seen, 1'b0);
  endtask

  task automatic watchdog;
    longint bits;
    bits = 2 * 90 * case_frame.size() + 40 * n_exp_words
         + MAX_GAP * case_frame.size() + 2 * 20; // frames, words, gaps, idle windows
    #(2 * bits * BIT_NS + 20 * CLK_NS);
    $display("watchdog expired with %0d of %0d words seen on tx_o", n_rx_words, n_exp_words);
    $display(">>> FAIL");
    $finish;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    rx_i        = 1'b1; // idle line
    seed        = 32'h1611e41b;
    n_rx_words  = 0;
    n_checks    = 0;
    n_errors    = 0;
    seen_bad    = 1'b0;
    read_cases();
    queue_expected();
    fork
      watchdog();
    join_none
    repeat (8) @(posedge clk);
    #1 rst_n_i = 1'b1;
    repeat (4) @(negedge clk);
    check_flag("tx_o", tx_o, 1'b1);
    check_flag("frame_err_o", frame_err_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    fork
      monitor_tx();
    join_none
    send_pass(1'b1);            // random gaps
    wait_idle(n_exp_words / 2);
    send_pass(1'b0);            // back to back
    wait_idle(n_exp_words);
    check_flag("frame_err_o", frame_err_o, seen_bad);
    sva_fails = dut.u_rx.rx_chk.fail_cnt + dut.u_split.split_chk.fail_cnt
              + dut.u_fifo.fifo_chk.fail_cnt + dut.u_tx.tx_chk.fail_cnt;
    n_errors += sva_fails;
    $display("checks %0d errors %0d assertion failures %0d words %0d of %0d",
             n_checks, n_errors, sva_fails, n_rx_words, n_exp_words);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
